// File: raycast_pkg.sv
package raycast_pkg;

    // ****************************************
    // fixed point and index types
    // ****************************************

    // signed 8.8, integer part in the upper byte
    typedef logic signed [15:0] fixed_t;

    // screen column, 0 to 319
    typedef logic [8:0] column_t;

    // map cell index, integer part of a position
    typedef logic [7:0] map_t;

    // camera pose number from the switches
    typedef logic [2:0] pose_sel_t;

    // credit count, 0 up to the receiver depth
    typedef logic [2:0] credit_t;

    // ****************************************
    // screen sweep and camera plane
    // ****************************************

    localparam int SCREEN_COLUMNS = 320;
    localparam column_t LAST_COLUMN = column_t'(SCREEN_COLUMNS - 1);

    // offset grows by 8/5 lsb per column, so -1.0 up to just under +1.0
    localparam int CAMERA_NUM = 8;
    localparam int CAMERA_DEN = 5;
    localparam fixed_t CAMERA_START = -16'sd256;

    // receiver buffer depth, full credit after reset
    localparam credit_t CREDIT_MAX = 3'd4;

    // ****************************************
    // camera pose table
    // ****************************************

    // player position, cells 11.5, 20.5 and 4.5
    localparam fixed_t POSE_POS_X [8] = '{
        16'h0b80, 16'h0b80, 16'h0b80, 16'h0b80, 16'h1480, 16'h0480, 16'h0480, 16'h1480
    };
    localparam fixed_t POSE_POS_Y [8] = '{
        16'h0b80, 16'h0b80, 16'h0b80, 16'h0b80, 16'h0480, 16'h0480, 16'h1480, 16'h1480
    };

    // view direction, unit axis or about 0.707 on the diagonals
    localparam fixed_t POSE_DIR_X [8] = '{
        16'h0100, 16'h00b5, 16'h0000, 16'hff4b, 16'h00b5, 16'hff4b, 16'h00b5, 16'hff4b
    };
    localparam fixed_t POSE_DIR_Y [8] = '{
        16'h0000, 16'h00b5, 16'h0100, 16'h00b5, 16'h00b5, 16'h00b5, 16'h00b5, 16'h00b5
    };

    // camera plane, perpendicular to dir, length about 0.66
    localparam fixed_t POSE_PLANE_X [8] = '{
        16'h0000, 16'hff89, 16'hff57, 16'hff89, 16'hff89, 16'hff89, 16'hff89, 16'hff89
    };
    localparam fixed_t POSE_PLANE_Y [8] = '{
        16'h00a9, 16'h0077, 16'h0000, 16'hff89, 16'h0077, 16'hff89, 16'h0077, 16'hff89
    };

endpackage

// File: pose_if.sv
`timescale 1ns/1ns

interface pose_if;

    // handshake, item moves when both are high
    logic valid;
    logic advance;

    // issued column and its camera offset
    raycast_pkg::column_t column;
    raycast_pkg::fixed_t camera_x;
    logic last;

    // pose of the frame this column belongs to
    raycast_pkg::fixed_t pos_x;
    raycast_pkg::fixed_t pos_y;
    raycast_pkg::fixed_t dir_x;
    raycast_pkg::fixed_t dir_y;
    raycast_pkg::fixed_t plane_x;
    raycast_pkg::fixed_t plane_y;

    modport decode (
        output valid, column, camera_x, last,
        output pos_x, pos_y, dir_x, dir_y, plane_x, plane_y,
        input advance
    );

    modport execute (
        input valid, column, camera_x, last,
        input pos_x, pos_y, dir_x, dir_y, plane_x, plane_y,
        output advance
    );

endinterface

// File: ray_if.sv
`timescale 1ns/1ns

interface ray_if;

    // handshake, ray moves when both are high
    logic valid;
    logic accept;

    // ray payload
    raycast_pkg::column_t column;
    raycast_pkg::fixed_t ray_dir_x;
    raycast_pkg::fixed_t ray_dir_y;
    raycast_pkg::map_t map_x;
    raycast_pkg::map_t map_y;
    logic last;

    modport execute (
        output valid, column, ray_dir_x, ray_dir_y, map_x, map_y, last,
        input accept
    );

    modport result (
        input valid, column, ray_dir_x, ray_dir_y, map_x, map_y, last,
        output accept
    );

endinterface

// File: pose_decode.sv
`timescale 1ns/1ns

module pose_decode (
    input logic clk_pixel,
    input logic sys_rst,
    input raycast_pkg::pose_sel_t pose_sel,
    pose_if.decode issue
);

    // one idle cycle after reset, then sweep forever
    typedef enum logic {
        DEC_IDLE,
        DEC_SWEEP
    } dec_state_t;

    dec_state_t state;

    raycast_pkg::column_t column;
    raycast_pkg::fixed_t camera_x;
    // fractional part of column * 8 / 5, in fifths of an lsb
    logic [2:0] rem;
    logic [3:0] rem_sum;
    // pose latched at column 0 for the rest of the frame
    raycast_pkg::pose_sel_t frame_sel;
    raycast_pkg::pose_sel_t sel_now;
    logic fire;

    assign fire = issue.valid && issue.advance;

    // column 0 looks at the switches directly,
    // so the pose is the one present at its transfer
    assign sel_now = (column == '0) ? pose_sel : frame_sel;

    assign rem_sum = {1'b0, rem} + 4'(raycast_pkg::CAMERA_NUM);

    // ****************************************
    // column stepper and camera accumulator
    // ****************************************

    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            state <= DEC_IDLE;
            column <= '0;
            camera_x <= raycast_pkg::CAMERA_START;
            rem <= '0;
            frame_sel <= '0;
        end else if (state == DEC_IDLE) begin
            state <= DEC_SWEEP;
        end else if (fire) begin
            if (column == '0) begin
                frame_sel <= pose_sel;
            end
            if (column == raycast_pkg::LAST_COLUMN) begin
                // wrap to the left edge of the next frame
                column <= '0;
                camera_x <= raycast_pkg::CAMERA_START;
                rem <= '0;
            end else begin
                column <= column + 9'd1;
                // carry whole lsbs out of the remainder
                if (rem_sum >= 4'(2 * raycast_pkg::CAMERA_DEN)) begin
                    camera_x <= camera_x + 16'sd2;
                    rem <= 3'(rem_sum - 4'(2 * raycast_pkg::CAMERA_DEN));
                end else if (rem_sum >= 4'(raycast_pkg::CAMERA_DEN)) begin
                    camera_x <= camera_x + 16'sd1;
                    rem <= 3'(rem_sum - 4'(raycast_pkg::CAMERA_DEN));
                end else begin
                    rem <= rem_sum[2:0];
                end
            end
        end
    end

    // ****************************************
    // issued item
    // ****************************************

    assign issue.valid = (state == DEC_SWEEP);
    assign issue.column = column;
    assign issue.camera_x = camera_x;
    assign issue.last = (column == raycast_pkg::LAST_COLUMN);

    // pose lookup in the shared table
    assign issue.pos_x = raycast_pkg::POSE_POS_X[sel_now];
    assign issue.pos_y = raycast_pkg::POSE_POS_Y[sel_now];
    assign issue.dir_x = raycast_pkg::POSE_DIR_X[sel_now];
    assign issue.dir_y = raycast_pkg::POSE_DIR_Y[sel_now];
    assign issue.plane_x = raycast_pkg::POSE_PLANE_X[sel_now];
    assign issue.plane_y = raycast_pkg::POSE_PLANE_Y[sel_now];

endmodule

// File: ray_execute.sv
`timescale 1ns/1ns

module ray_execute (
    input logic clk_pixel,
    input logic sys_rst,
    pose_if.execute issue,
    ray_if.execute ray
);

    // ****************************************
    // stage 1, plane times camera offset
    // ****************************************

    logic s1_valid;
    raycast_pkg::column_t s1_column;
    logic s1_last;
    // full 16x16 signed products, 16.16 format
    logic signed [31:0] s1_prod_x;
    logic signed [31:0] s1_prod_y;
    raycast_pkg::fixed_t s1_dir_x;
    raycast_pkg::fixed_t s1_dir_y;
    raycast_pkg::map_t s1_map_x;
    raycast_pkg::map_t s1_map_y;

    // ****************************************
    // stage 2, scale back and add direction
    // ****************************************

    logic s2_valid;
    raycast_pkg::column_t s2_column;
    logic s2_last;
    raycast_pkg::fixed_t s2_ray_dir_x;
    raycast_pkg::fixed_t s2_ray_dir_y;
    raycast_pkg::map_t s2_map_x;
    raycast_pkg::map_t s2_map_y;

    // whole pipe moves as one, stalls on back-pressure
    assign issue.advance = ray.accept;

    // valid bits
    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (ray.accept) begin
            s1_valid <= issue.valid;
            s2_valid <= s1_valid;
        end
    end

    // payload
    always_ff @(posedge clk_pixel) begin
        if (ray.accept) begin
            s1_column <= issue.column;
            s1_last <= issue.last;
            s1_prod_x <= issue.plane_x * issue.camera_x;
            s1_prod_y <= issue.plane_y * issue.camera_x;
            s1_dir_x <= issue.dir_x;
            s1_dir_y <= issue.dir_y;
            // player cell is the integer byte of the position
            s1_map_x <= issue.pos_x[15:8];
            s1_map_y <= issue.pos_y[15:8];

            s2_column <= s1_column;
            s2_last <= s1_last;
            // bits 23:8 give the product back in 8.8, sum wraps at 16 bits
            s2_ray_dir_x <= raycast_pkg::fixed_t'(s1_prod_x[23:8]) + s1_dir_x;
            s2_ray_dir_y <= raycast_pkg::fixed_t'(s1_prod_y[23:8]) + s1_dir_y;
            s2_map_x <= s1_map_x;
            s2_map_y <= s1_map_y;
        end
    end

    // computed ray out to the result stage
    assign ray.valid = s2_valid;
    assign ray.column = s2_column;
    assign ray.ray_dir_x = s2_ray_dir_x;
    assign ray.ray_dir_y = s2_ray_dir_y;
    assign ray.map_x = s2_map_x;
    assign ray.map_y = s2_map_y;
    assign ray.last = s2_last;

endmodule

// File: ray_result.sv
`timescale 1ns/1ns

module ray_result (
    input logic clk_pixel,
    input logic sys_rst,
    ray_if.result ray,
    input logic credit_return,
    output logic ray_valid,
    output raycast_pkg::column_t ray_column,
    output raycast_pkg::fixed_t ray_dir_x,
    output raycast_pkg::fixed_t ray_dir_y,
    output raycast_pkg::map_t map_x,
    output raycast_pkg::map_t map_y,
    output logic ray_last
);

    // one entry output register
    logic entry_full;
    raycast_pkg::credit_t credits;
    logic fire;
    logic load;

    // send only with a credit in hand
    assign fire = entry_full && (credits != '0);
    // room when empty or when the entry leaves this cycle
    assign ray.accept = !entry_full || fire;
    assign load = ray.valid && ray.accept;

    assign ray_valid = fire;

    // ****************************************
    // entry state and credit counter
    // ****************************************

    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            entry_full <= 1'b0;
            credits <= raycast_pkg::CREDIT_MAX;
        end else begin
            if (load) begin
                entry_full <= 1'b1;
            end else if (fire) begin
                entry_full <= 1'b0;
            end
            // spend and return may land together
            credits <= credits - {2'b00, fire} + {2'b00, credit_return};
        end
    end

    // fields stay put while ray_valid is high
    always_ff @(posedge clk_pixel) begin
        if (load) begin
            ray_column <= ray.column;
            ray_dir_x <= ray.ray_dir_x;
            ray_dir_y <= ray.ray_dir_y;
            map_x <= ray.map_x;
            map_y <= ray.map_y;
            ray_last <= ray.last;
        end
    end

endmodule

// File: raycast_top.sv
`timescale 1ns/1ns

module raycast_top (
    input logic clk_pixel,
    input logic sys_rst,
    input raycast_pkg::pose_sel_t pose_sel,
    input logic credit_return,
    output logic ray_valid,
    output raycast_pkg::column_t ray_column,
    output raycast_pkg::fixed_t ray_dir_x,
    output raycast_pkg::fixed_t ray_dir_y,
    output raycast_pkg::map_t map_x,
    output raycast_pkg::map_t map_y,
    output logic ray_last
);

    // decode to execute
    pose_if issue_bus ();
    // execute to result
    ray_if ray_bus ();

    // ****************************************
    // ray setup pipeline
    // ****************************************

    // column sweep and frame pose
    pose_decode pose_decode0 (
        .clk_pixel(clk_pixel),
        .sys_rst(sys_rst),
        .pose_sel(pose_sel),
        .issue(issue_bus.decode)
    );

    // ray direction and map cell
    ray_execute ray_execute0 (
        .clk_pixel(clk_pixel),
        .sys_rst(sys_rst),
        .issue(issue_bus.execute),
        .ray(ray_bus.execute)
    );

    // credit based output port
    ray_result ray_result0 (
        .clk_pixel(clk_pixel),
        .sys_rst(sys_rst),
        .ray(ray_bus.result),
        .credit_return(credit_return),
        .ray_valid(ray_valid),
        .ray_column(ray_column),
        .ray_dir_x(ray_dir_x),
        .ray_dir_y(ray_dir_y),
        .map_x(map_x),
        .map_y(map_y),
        .ray_last(ray_last)
    );

endmodule

// File: tb_raycast_properties.sv
`timescale 1ns/1ns

module tb_raycast_properties (
    input logic clk_pixel,
    input logic sys_rst,
    input logic ray_valid,
    input logic ray_last,
    input raycast_pkg::column_t ray_column,
    input raycast_pkg::credit_t credits,
    input logic credit_return
);

    // rays sent and not yet credited back, kept apart from the counter
    int outstanding;

    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(ray_valid) - int'(credit_return);
        end
    end

    // ****************************************
    // credit rules
    // ****************************************

    // a ray only leaves while the receiver still has room
    send_needs_credit: assert property (@(posedge clk_pixel) disable iff (sys_rst)
        ray_valid |-> outstanding < int'(raycast_pkg::CREDIT_MAX))
        else $error("ray_valid high with the receiver buffer full");

    // receiver never hands back more than it holds
    return_bounded: assert property (@(posedge clk_pixel) disable iff (sys_rst)
        credit_return && !ray_valid |-> credits < raycast_pkg::CREDIT_MAX)
        else $error("credit returned with the counter already full");

    // ****************************************
    // output rules
    // ****************************************

    // quiet in reset and in the cycle after it
    quiet_in_reset: assert property (@(posedge clk_pixel) sys_rst |-> !ray_valid)
        else $error("ray_valid high during reset");
    quiet_after_reset: assert property (@(posedge clk_pixel) sys_rst |=> !ray_valid)
        else $error("ray_valid high in the first cycle after reset");

    // last flag only on the right screen edge
    last_on_edge: assert property (@(posedge clk_pixel) disable iff (sys_rst)
        ray_valid |-> ray_last == (ray_column == raycast_pkg::LAST_COLUMN))
        else $error("ray_last does not match column 319");

endmodule

bind ray_result tb_raycast_properties props0 (
    .clk_pixel(clk_pixel),
    .sys_rst(sys_rst),
    .ray_valid(ray_valid),
    .ray_last(ray_last),
    .ray_column(ray_column),
    .credits(credits),
    .credit_return(credit_return)
);

// File: tb_raycast.sv
`timescale 1ns/1ns

module tb_raycast;

    // nine frames, the first at the reset pose and then all eight poses in turn
    localparam int NUM_FRAMES = 9;
    localparam int TOTAL_RAYS = NUM_FRAMES * raycast_pkg::SCREEN_COLUMNS;
    // eight cycles per ray, far above the credit stall rate
    localparam int TIMEOUT_CYCLES = TOTAL_RAYS * 8;

    logic clk_pixel = 1'b0;
    logic sys_rst;
    raycast_pkg::pose_sel_t pose_sel;
    logic credit_return;
    logic ray_valid;
    raycast_pkg::column_t ray_column;
    raycast_pkg::fixed_t ray_dir_x;
    raycast_pkg::fixed_t ray_dir_y;
    raycast_pkg::map_t map_x;
    raycast_pkg::map_t map_y;
    logic ray_last;

    logic [31:0] lfsr_state;
    logic [2:0] pose_base;
    logic timed_out;
    logic just_reset = 1'b0;
    int cycles = 0;
    int value_errors = 0;
    int protocol_errors = 0;
    int rays_checked = 0;
    // receiver side credit bookkeeping
    int rays_sent = 0;
    int rays_returned = 0;
    int pause = 0;
    // pose switching inside a frame
    int frames_issued = 0;
    int frames_seen = 0;
    int frame_cycle = 0;
    int first_change = -1;
    int second_change = -1;
    // model state, poses captured when column 0 leaves decode
    raycast_pkg::column_t expect_column = '0;
    raycast_pkg::pose_sel_t frame_pose = '0;
    raycast_pkg::pose_sel_t pose_queue [$];

    raycast_top dut0 (.*);

    initial begin
        forever #2 clk_pixel = ~clk_pixel;
    end

    // ****************************************
    // random numbers
    // ****************************************

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // ****************************************
    // model
    // ****************************************

    // floor(col * 8 / 5) up from -1.0
    function automatic raycast_pkg::fixed_t camera_offset(input raycast_pkg::column_t col);
        return raycast_pkg::fixed_t'(int'(col) * raycast_pkg::CAMERA_NUM
            / raycast_pkg::CAMERA_DEN + int'(raycast_pkg::CAMERA_START));
    endfunction

    // dir + plane * cam in 8.8, wraps at 16 bits
    function automatic raycast_pkg::fixed_t ray_component(input raycast_pkg::fixed_t dir,
            input raycast_pkg::fixed_t plane, input raycast_pkg::fixed_t cam);
        int product;
        product = int'(plane) * int'(cam);
        return raycast_pkg::fixed_t'(product >>> 8) + dir;
    endfunction

    task automatic compare_fixed(input string name, input raycast_pkg::fixed_t actual,
            input raycast_pkg::fixed_t expected);
        if (actual !== expected) begin
            value_errors++;
            $display("FAILED %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic compare_column(input string name, input raycast_pkg::column_t actual,
            input raycast_pkg::column_t expected);
        if (actual !== expected) begin
            value_errors++;
            $display("FAILED %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic compare_map(input string name, input raycast_pkg::map_t actual,
            input raycast_pkg::map_t expected);
        if (actual !== expected) begin
            value_errors++;
            $display("FAILED %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic compare_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            value_errors++;
            $display("FAILED %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic check_ray();
        raycast_pkg::fixed_t cam;
        raycast_pkg::fixed_t pos_x;
        raycast_pkg::fixed_t pos_y;
        // new frame takes the oldest captured pose
        if (expect_column == '0) begin
            if (pose_queue.size() == 0) begin
                protocol_errors++;
                $display("ray for column 0 arrived before its frame was issued");
            end else begin
                frame_pose = pose_queue.pop_front();
            end
        end
        cam = camera_offset(expect_column);
        pos_x = raycast_pkg::POSE_POS_X[frame_pose];
        pos_y = raycast_pkg::POSE_POS_Y[frame_pose];
        compare_column("ray_column", ray_column, expect_column);
        compare_flag("ray_last", ray_last, expect_column == raycast_pkg::LAST_COLUMN);
        compare_fixed("ray_dir_x", ray_dir_x, ray_component(raycast_pkg::POSE_DIR_X[frame_pose],
            raycast_pkg::POSE_PLANE_X[frame_pose], cam));
        compare_fixed("ray_dir_y", ray_dir_y, ray_component(raycast_pkg::POSE_DIR_Y[frame_pose],
            raycast_pkg::POSE_PLANE_Y[frame_pose], cam));
        compare_map("map_x", map_x, pos_x[15:8]);
        compare_map("map_y", map_y, pos_y[15:8]);
        if (expect_column == raycast_pkg::LAST_COLUMN) begin
            expect_column = '0;
        end else begin
            expect_column = expect_column + 9'd1;
        end
        rays_checked++;
    endtask

    // ****************************************
    // sampling at the falling edge
    // ****************************************

    always @(negedge clk_pixel) begin
        if (sys_rst) begin
            just_reset = 1'b1;
            if (ray_valid) begin
                protocol_errors++;
                $display("ray_valid was high during reset");
            end
        end else begin
            if (just_reset && ray_valid) begin
                protocol_errors++;
                $display("ray_valid was high in the first cycle after reset");
            end
            just_reset = 1'b0;
            // column 0 transfer fixes the pose of its frame
            if (dut0.pose_decode0.fire && dut0.pose_decode0.column == '0) begin
                pose_queue.push_back(pose_sel);
                frames_issued++;
            end
            if (ray_valid) begin
                if (rays_sent - rays_returned >= int'(raycast_pkg::CREDIT_MAX)) begin
                    protocol_errors++;
                    $display("a ray was sent with no credit left");
                end
                check_ray();
                rays_sent++;
            end
            if (credit_return) begin
                rays_returned++;
            end
        end
    end

    // ****************************************
    // stimulus at the rising edge
    // ****************************************

    always @(posedge clk_pixel) begin
        cycles <= cycles + 1;
        if (!sys_rst) begin
            // two switch changes per frame, both well before the next column 0
            if (frames_issued != frames_seen) begin
                frames_seen = frames_issued;
                frame_cycle = 0;
                first_change = 1 + int'(random_bits(6));
                second_change = 128 + int'(random_bits(7));
            end else begin
                frame_cycle++;
            end
            if (frame_cycle == first_change) begin
                pose_sel <= raycast_pkg::pose_sel_t'(random_bits(3));
            end
            // odd stride walks through all eight poses
            if (frame_cycle == second_change) begin
                pose_sel <= raycast_pkg::pose_sel_t'(int'(pose_base) + 5 * frames_seen);
            end
            if (pause > 0) begin
                pause = pause - 1;
                credit_return <= 1'b0;
            end else if (random_bits(6) == 32'd0) begin
                // receiver stall
                pause = int'(random_bits(5));
                credit_return <= 1'b0;
            end else begin
                credit_return <= (rays_sent > rays_returned) && (random_bits(1) == 32'd1);
            end
        end
    end

    initial begin
        lfsr_state = 32'h21dc_daa0;
        sys_rst = 1'b1;
        credit_return = 1'b0;
        timed_out = 1'b0;
        pose_base = 3'(random_bits(3));
        pose_sel = raycast_pkg::pose_sel_t'(random_bits(3));
        repeat (16) @(posedge clk_pixel);
        sys_rst <= 1'b0;
        while (rays_checked < TOTAL_RAYS && !timed_out) begin
            @(posedge clk_pixel);
            if (cycles >= TIMEOUT_CYCLES) begin
                timed_out = 1'b1;
            end
        end
        if (timed_out) begin
            $display("run reached the cycle limit of %0d with %0d of %0d rays checked",
                TIMEOUT_CYCLES, rays_checked, TOTAL_RAYS);
        end
        $display("errors: %0d value, %0d protocol, %0d timeout",
            value_errors, protocol_errors, timed_out);
        if (value_errors == 0 && protocol_errors == 0 && !timed_out) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: sim.f
raycast_pkg.sv
pose_if.sv
ray_if.sv
pose_decode.sv
ray_execute.sv
ray_result.sv
raycast_top.sv
tb_raycast_properties.sv
tb_raycast.sv

// File: Makefile
# ray setup testbench on Verilator

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run tb_raycast, passes when sim.log holds the pass message"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_raycast \
		-Mdir obj_dir -f sim.f
	-./obj_dir/Vtb_raycast +verilator+error+limit+1000 > sim.log 2>&1
	@cat sim.log
	@grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log
